//--- logic/soc_pkg.sv
//--------------------------------------------------------------------------
// Shared definitions for the memory-mapped subsystem
// Address map, register offsets and widths
// Bus request/response structs, SRAM pin struct, address union
//--------------------------------------------------------------------------

package soc_pkg;

	// Bus widths
	localparam int BUS_DW    = 32;
	localparam int BUS_SEL_W = 4;

	// One bus address, seen as memory region or peripheral page
	typedef union packed {
		struct packed {
			logic [2:0]  region;
			logic [28:0] offset;
		} mem;
		struct packed {
			logic [14:0] page;
			logic [16:0] offset;
		} per;
	} bus_addr_u;

	typedef struct packed {
		logic                 stb;
		logic                 we;
		logic [BUS_SEL_W-1:0] sel;
		bus_addr_u            adr;
		logic [BUS_DW-1:0]    wdat;
	} bus_req_t;

	typedef struct packed {
		logic              ack;
		logic [BUS_DW-1:0] rdat;
	} bus_rsp_t;

	//----------------------------------------------------------------------
	// Address map
	//----------------------------------------------------------------------
	localparam logic [2:0]  REGION_SRAM = 3'h4;
	// Pages only count outside the SRAM region
	localparam logic [14:0] PAGE_BRAM   = 15'h0000;
	localparam logic [14:0] PAGE_TIMER  = 15'h7001;
	localparam logic [14:0] PAGE_GPIO   = 15'h7002;

	// Block RAM byte size as log2, 4 KB
	localparam int BRAM_ADR_W = 12;

	// External SRAM
	localparam int SRAM_ADR_W   = 23;
	localparam int SRAM_LATENCY = 5;
	localparam int SRAM_CNT_W   = $clog2(SRAM_LATENCY);
	localparam logic [SRAM_CNT_W-1:0] SRAM_CNT_LAST = SRAM_CNT_W'(SRAM_LATENCY - 1);

	typedef struct packed {
		logic [SRAM_ADR_W-1:0] adr;
		logic [15:0]           dq;
		logic                  dq_oe;
		logic [1:0]            be_n;
		logic                  ce_n;
		logic                  oe_n;
		logic                  we_n;
	} mem_pins_t;

	// Pins with no access running
	localparam mem_pins_t MEM_PINS_IDLE = '{adr: '0, dq: '0, dq_oe: 1'b0, be_n: 2'b11,
		ce_n: 1'b1, oe_n: 1'b1, we_n: 1'b1};

	//----------------------------------------------------------------------
	// Timer registers
	//----------------------------------------------------------------------
	localparam logic [3:0] TMR_CTRL    = 4'h0;
	localparam logic [3:0] TMR_COMPARE = 4'h4;
	localparam logic [3:0] TMR_COUNTER = 4'h8;

	// CTRL bits
	localparam int TMR_EN  = 0;
	localparam int TMR_AR  = 1;
	localparam int TMR_IE  = 2;
	localparam int TMR_EXP = 3;

	//----------------------------------------------------------------------
	// GPIO registers
	//----------------------------------------------------------------------
	localparam logic [3:0] GPIO_IN   = 4'h0;
	localparam logic [3:0] GPIO_OUT  = 4'h4;
	localparam logic [3:0] GPIO_MASK = 4'h8;
	localparam int GPIO_W = 8;

	// Interrupt vector positions
	localparam int IRQ_TIMER = 0;
	localparam int IRQ_GPIO  = 1;

endpackage

//--- logic/soc_bus_decoder.sv
//--------------------------------------------------------------------------
// Bus decoder for one master and four slaves
// Address decode, strobe routing, response mux, unmapped answer
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module soc_bus_decoder (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::bus_rsp_t rsp_o,
	output soc_pkg::bus_req_t bram_req_o,
	output soc_pkg::bus_req_t sram_req_o,
	output soc_pkg::bus_req_t tmr_req_o,
	output soc_pkg::bus_req_t gpio_req_o,
	input  soc_pkg::bus_rsp_t bram_rsp_i,
	input  soc_pkg::bus_rsp_t sram_rsp_i,
	input  soc_pkg::bus_rsp_t tmr_rsp_i,
	input  soc_pkg::bus_rsp_t gpio_rsp_i
);
	import soc_pkg::*;

	logic hit_sram, hit_bram, hit_tmr, hit_gpio, hit_none;
	logic unm_stb;
	logic unm_ack_q;

	// SRAM region wins over any page match
	assign hit_sram = (req_i.adr.mem.region == REGION_SRAM);
	assign hit_bram = !hit_sram && (req_i.adr.per.page == PAGE_BRAM);
	assign hit_tmr  = !hit_sram && (req_i.adr.per.page == PAGE_TIMER);
	assign hit_gpio = !hit_sram && (req_i.adr.per.page == PAGE_GPIO);
	assign hit_none = !(hit_sram || hit_bram || hit_tmr || hit_gpio);
	assign unm_stb  = req_i.stb && hit_none;

	// Each slave sees the request, strobe only when addressed
	always_comb begin
		bram_req_o     = req_i;
		sram_req_o     = req_i;
		tmr_req_o      = req_i;
		gpio_req_o     = req_i;
		bram_req_o.stb = req_i.stb && hit_bram;
		sram_req_o.stb = req_i.stb && hit_sram;
		tmr_req_o.stb  = req_i.stb && hit_tmr;
		gpio_req_o.stb = req_i.stb && hit_gpio;
	end

	// Unmapped address gets a one-cycle ack, no repeat
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			unm_ack_q <= 1'b0;
		end else begin
			unm_ack_q <= unm_stb && !unm_ack_q;
		end
	end

	// Response from the addressed slave
	always_comb begin
		if (hit_sram) begin
			rsp_o = sram_rsp_i;
		end else if (hit_bram) begin
			rsp_o = bram_rsp_i;
		end else if (hit_tmr) begin
			rsp_o = tmr_rsp_i;
		end else if (hit_gpio) begin
			rsp_o = gpio_rsp_i;
		end else begin
			rsp_o = '{ack: unm_ack_q, rdat: '0};
		end
	end

	// Only one target strobed per cycle, unmapped answer included
	one_target_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$onehot0({bram_req_o.stb, sram_req_o.stb, tmr_req_o.stb, gpio_req_o.stb, unm_stb}));

endmodule

//--- logic/soc_bram.sv
//--------------------------------------------------------------------------
// On-chip block RAM slave
// Word wide, byte-select writes, single-cycle ack
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module soc_bram (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::bus_rsp_t rsp_o
);
	import soc_pkg::*;

	logic [BUS_DW-1:0]       mem [2**(BRAM_ADR_W-2)];
	logic [BRAM_ADR_W-3:0]   word_adr;
	logic [BUS_DW-1:0]       rdat_q;
	logic                    ack_q;

	// Upper offset bits alias
	assign word_adr = req_i.adr.per.offset[BRAM_ADR_W-1:2];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req_i.stb && !ack_q;
		end
	end

	// Access once per request, in the cycle before ack
	always_ff @(posedge clk_i) begin
		if (req_i.stb && !ack_q) begin
			if (req_i.we) begin
				for (int i = 0; i < BUS_SEL_W; i++) begin
					if (req_i.sel[i]) begin
						mem[word_adr][8*i +: 8] <= req_i.wdat[8*i +: 8];
					end
				end
			end
			rdat_q <= mem[word_adr];
		end
	end

	assign rsp_o = '{ack: ack_q, rdat: rdat_q};

endmodule

//--- logic/soc_sram16_ctrl.sv
//--------------------------------------------------------------------------
// External 16-bit SRAM controller
// Two timed halfword cycles per 32-bit access, low half first
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module soc_sram16_ctrl (
	input  logic               clk_i,
	input  logic               arst_n_i,
	input  soc_pkg::bus_req_t  req_i,
	output soc_pkg::bus_rsp_t  rsp_o,
	input  logic [15:0]        mem_dq_i,
	output soc_pkg::mem_pins_t mem_o
);
	import soc_pkg::*;

	logic                  busy_q;
	logic                  half_q;
	logic [SRAM_CNT_W-1:0] cnt_q;
	logic                  ack_q;
	mem_pins_t             mem_q;
	logic [BUS_DW-1:0]     rdat_q;

	// Pin values for one halfword access
	function automatic mem_pins_t half_pins(input bus_req_t req, input logic hi);
		mem_pins_t p;
		logic [1:0] sel2;
		logic       skip;
		sel2    = hi ? req.sel[3:2] : req.sel[1:0];
		// No byte of this half selected
		skip    = ~|sel2;
		p.adr   = {req.adr.mem.offset[SRAM_ADR_W:2], hi};
		p.dq    = hi ? req.wdat[31:16] : req.wdat[15:0];
		p.dq_oe = req.we && !skip;
		p.be_n  = ~sel2;
		p.ce_n  = skip;
		p.oe_n  = req.we || skip;
		p.we_n  = !req.we || skip;
		return p;
	endfunction

	//----------------------------------------------------------------------
	// Access sequencer
	//----------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= 1'b0;
			half_q <= 1'b0;
			cnt_q  <= '0;
			ack_q  <= 1'b0;
			mem_q  <= MEM_PINS_IDLE;
		end else begin
			ack_q <= 1'b0;
			if (!busy_q) begin
				// New request, ack of the last one already gone
				if (req_i.stb && !ack_q) begin
					busy_q <= 1'b1;
					half_q <= 1'b0;
					cnt_q  <= SRAM_CNT_LAST;
					mem_q  <= half_pins(req_i, 1'b0);
				end
			end else if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end else if (!half_q) begin
				// Low half done, on to the high half
				half_q <= 1'b1;
				cnt_q  <= SRAM_CNT_LAST;
				mem_q  <= half_pins(req_i, 1'b1);
			end else begin
				busy_q <= 1'b0;
				ack_q  <= 1'b1;
				mem_q  <= MEM_PINS_IDLE;
			end
		end
	end

	// Read data sampled at the end of each access time
	always_ff @(posedge clk_i) begin
		if (busy_q && cnt_q == '0) begin
			if (half_q) begin
				rdat_q[31:16] <= mem_q.oe_n ? 16'h0000 : mem_dq_i;
			end else begin
				rdat_q[15:0] <= mem_q.oe_n ? 16'h0000 : mem_dq_i;
			end
		end
	end

	assign mem_o = mem_q;
	assign rsp_o = '{ack: ack_q, rdat: rdat_q};

	// No bus fight on the data pins
	dq_no_fight_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(mem_o.dq_oe && !mem_o.oe_n));

endmodule

//--- logic/soc_timer.sv
//--------------------------------------------------------------------------
// One-channel compare timer
// CTRL, COMPARE and COUNTER registers, autoreload, interrupt
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module soc_timer (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::bus_rsp_t rsp_o,
	output logic              irq_o
);
	import soc_pkg::*;

	logic [3:0]        ctrl_q;
	logic [BUS_DW-1:0] compare_q;
	logic [BUS_DW-1:0] counter_q;
	logic [BUS_DW-1:0] rdat_q;
	logic [3:0]        off;
	logic              ack_q;
	logic              wr;
	logic              hit;

	assign off = req_i.adr.per.offset[3:0];
	// Single write per request
	assign wr  = req_i.stb && req_i.we && !ack_q;
	assign hit = ctrl_q[TMR_EN] && (counter_q == compare_q);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q     <= 1'b0;
			ctrl_q    <= '0;
			compare_q <= '0;
			counter_q <= '0;
		end else begin
			ack_q <= req_i.stb && !ack_q;
			// Bus write beats counting
			if (wr && off == TMR_COUNTER) begin
				counter_q <= req_i.wdat;
			end else if (hit) begin
				counter_q <= '0;
			end else if (ctrl_q[TMR_EN]) begin
				counter_q <= counter_q + 1'b1;
			end
			if (wr && off == TMR_COMPARE) begin
				compare_q <= req_i.wdat;
			end
			if (wr && off == TMR_CTRL) begin
				ctrl_q[TMR_EN] <= req_i.wdat[TMR_EN];
				ctrl_q[TMR_AR] <= req_i.wdat[TMR_AR];
				ctrl_q[TMR_IE] <= req_i.wdat[TMR_IE];
			end else if (hit && !ctrl_q[TMR_AR]) begin
				// One-shot stops at expiry
				ctrl_q[TMR_EN] <= 1'b0;
			end
			// Expiry wins over a clear in the same cycle
			if (hit) begin
				ctrl_q[TMR_EXP] <= 1'b1;
			end else if (wr && off == TMR_CTRL && req_i.wdat[TMR_EXP]) begin
				ctrl_q[TMR_EXP] <= 1'b0;
			end
		end
	end

	// Read mux
	always_ff @(posedge clk_i) begin
		if (req_i.stb && !ack_q) begin
			case (off)
				TMR_CTRL:    rdat_q <= BUS_DW'(ctrl_q);
				TMR_COMPARE: rdat_q <= compare_q;
				TMR_COUNTER: rdat_q <= counter_q;
				default:     rdat_q <= '0;
			endcase
		end
	end

	assign rsp_o = '{ack: ack_q, rdat: rdat_q};
	assign irq_o = ctrl_q[TMR_EXP] && ctrl_q[TMR_IE];

endmodule

//--- logic/soc_gpio.sv
//--------------------------------------------------------------------------
// GPIO block
// Output register, 2-flop input synchronizer, masked level interrupt
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module soc_gpio (
	input  logic                       clk_i,
	input  logic                       arst_n_i,
	input  soc_pkg::bus_req_t          req_i,
	output soc_pkg::bus_rsp_t          rsp_o,
	input  logic [soc_pkg::GPIO_W-1:0] gpio_i,
	output logic [soc_pkg::GPIO_W-1:0] gpio_o,
	output logic                       irq_o
);
	import soc_pkg::*;

	logic [GPIO_W-1:0] meta_q;
	logic [GPIO_W-1:0] sync_q;
	logic [GPIO_W-1:0] out_q;
	logic [GPIO_W-1:0] mask_q;
	logic [BUS_DW-1:0] rdat_q;
	logic [3:0]        off;
	logic              ack_q;

	assign off = req_i.adr.per.offset[3:0];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			meta_q <= '0;
			sync_q <= '0;
			out_q  <= '0;
			mask_q <= '0;
			ack_q  <= 1'b0;
		end else begin
			// Buttons are asynchronous
			meta_q <= gpio_i;
			sync_q <= meta_q;
			ack_q  <= req_i.stb && !ack_q;
			if (req_i.stb && req_i.we && !ack_q) begin
				if (off == GPIO_OUT) begin
					out_q <= req_i.wdat[GPIO_W-1:0];
				end
				if (off == GPIO_MASK) begin
					mask_q <= req_i.wdat[GPIO_W-1:0];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_i.stb && !ack_q) begin
			case (off)
				GPIO_IN:   rdat_q <= BUS_DW'(sync_q);
				GPIO_OUT:  rdat_q <= BUS_DW'(out_q);
				GPIO_MASK: rdat_q <= BUS_DW'(mask_q);
				default:   rdat_q <= '0;
			endcase
		end
	end

	assign rsp_o  = '{ack: ack_q, rdat: rdat_q};
	assign gpio_o = out_q;
	// Level interrupt, any enabled input high
	assign irq_o  = |(sync_q & mask_q);

endmodule

//--- logic/soc_top.sv
//--------------------------------------------------------------------------
// Subsystem top level
// Bus decoder, block RAM, SRAM controller, timer, GPIO
// Active-low interrupt vector
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module soc_top (
	input  logic                       clk_i,
	input  logic                       arst_n_i,
	input  soc_pkg::bus_req_t          bus_req_i,
	output soc_pkg::bus_rsp_t          bus_rsp_o,
	output soc_pkg::mem_pins_t         mem_o,
	input  logic [15:0]                mem_dq_i,
	input  logic [soc_pkg::GPIO_W-1:0] gpio_i,
	output logic [soc_pkg::GPIO_W-1:0] gpio_o,
	output logic [1:0]                 irq_n_o
);
	import soc_pkg::*;

	bus_req_t bram_req, sram_req, tmr_req, gpio_req;
	bus_rsp_t bram_rsp, sram_rsp, tmr_rsp, gpio_rsp;
	logic     tmr_irq;
	logic     gpio_irq;

	//----------------------------------------------------------------------
	// Interconnect
	//----------------------------------------------------------------------
	soc_bus_decoder decoder_inst (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.req_i      (bus_req_i),
		.rsp_o      (bus_rsp_o),
		.bram_req_o (bram_req),
		.sram_req_o (sram_req),
		.tmr_req_o  (tmr_req),
		.gpio_req_o (gpio_req),
		.bram_rsp_i (bram_rsp),
		.sram_rsp_i (sram_rsp),
		.tmr_rsp_i  (tmr_rsp),
		.gpio_rsp_i (gpio_rsp)
	);

	//----------------------------------------------------------------------
	// Memories
	//----------------------------------------------------------------------
	soc_bram bram_inst (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.req_i    (bram_req),
		.rsp_o    (bram_rsp)
	);

	// Owns the memory pins alone
	soc_sram16_ctrl sram_inst (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.req_i    (sram_req),
		.rsp_o    (sram_rsp),
		.mem_dq_i (mem_dq_i),
		.mem_o    (mem_o)
	);

	//----------------------------------------------------------------------
	// Peripherals
	//----------------------------------------------------------------------
	soc_timer timer_inst (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.req_i    (tmr_req),
		.rsp_o    (tmr_rsp),
		.irq_o    (tmr_irq)
	);

	soc_gpio gpio_inst (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.req_i    (gpio_req),
		.rsp_o    (gpio_rsp),
		.gpio_i   (gpio_i),
		.gpio_o   (gpio_o),
		.irq_o    (gpio_irq)
	);

	// Interrupts go out active low
	always_comb begin
		irq_n_o            = '1;
		irq_n_o[IRQ_TIMER] = !tmr_irq;
		irq_n_o[IRQ_GPIO]  = !gpio_irq;
	end

endmodule

//--- tb/tb_soc_tests.svh
//--------------------------------------------------------------------------
// Directed tests for the subsystem testbench
// Reset state, BRAM, SRAM, timer, GPIO, unmapped address
//--------------------------------------------------------------------------

task automatic test_reset_state();
	@(negedge clk);
	if (bus_rsp.ack !== 1'b0) begin
		value_error("reset_state", 32'h0, bus_rsp.ack);
	end
	// ce_n, oe_n, we_n all idle high
	if ({mem_pins.ce_n, mem_pins.oe_n, mem_pins.we_n} !== 3'b111) begin
		value_error("reset_state", 32'h7, {mem_pins.ce_n, mem_pins.oe_n, mem_pins.we_n});
	end
	if (mem_pins.dq_oe !== 1'b0) begin
		value_error("reset_state", 32'h0, mem_pins.dq_oe);
	end
	if (irq_n !== 2'b11) begin
		value_error("reset_state", 32'h3, irq_n);
	end
	if (gpio_out !== '0) begin
		value_error("reset_state", 32'h0, gpio_out);
	end
	end_test("reset_state");
endtask

//--------------------------------------------------------------------------
// Memories
//--------------------------------------------------------------------------
// Full write, then partial writes each followed by a readback
task automatic merge_run(input string name, input logic [31:0] base, input logic pins);
	logic [31:0] offs [4];
	logic [3:0]  sels [5];
	logic [31:0] adr;
	logic [31:0] exp;
	logic [31:0] wdat;
	logic [31:0] rdat;
	logic [9:0]  hw;
	offs = '{32'h000, 32'h044, 32'h3f8, 32'h7fc};
	sels = '{4'b0011, 4'b1100, 4'b0101, 4'b1000, 4'b0000};
	for (int k = 0; k < 4; k++) begin
		adr = base + offs[k];
		exp = rand_bits(32);
		bus_write(adr, 4'hf, exp);
		for (int j = 0; j < 5; j++) begin
			wdat = rand_bits(32);
			bus_write(adr, sels[j], wdat);
			exp = merge_bytes(exp, wdat, sels[j]);
			bus_read(adr, rdat);
			if (rdat !== exp) begin
				value_error(name, exp, rdat);
			end
			// Low half at the even halfword
			hw = adr[10:1];
			if (pins && {sram_model[hw + 10'd1], sram_model[hw]} !== exp) begin
				value_error(name, exp, {sram_model[hw + 10'd1], sram_model[hw]});
			end
		end
	end
endtask

task automatic test_bram();
	merge_run("bram", BRAM_BASE, 1'b0);
	end_test("bram");
endtask

task automatic test_sram();
	merge_run("sram", SRAM_BASE, 1'b1);
	end_test("sram");
endtask

//--------------------------------------------------------------------------
// Peripherals
//--------------------------------------------------------------------------
task automatic test_timer();
	logic [31:0] rdat;
	int          polls;
	rdat  = '0;
	polls = 0;
	bus_write(TMR_BASE + TMR_COMPARE, 4'hf, 32'd20);
	bus_write(TMR_BASE + TMR_CTRL, 4'hf, (32'd1 << TMR_EN) | (32'd1 << TMR_IE));
	while (!rdat[TMR_EXP] && polls < 50) begin
		bus_read(TMR_BASE + TMR_CTRL, rdat);
		polls++;
	end
	// One-shot, so EN is gone when EXP shows
	if (rdat !== ((32'd1 << TMR_EXP) | (32'd1 << TMR_IE))) begin
		value_error("timer", (32'd1 << TMR_EXP) | (32'd1 << TMR_IE), rdat);
	end
	if (irq_n[IRQ_TIMER] !== 1'b0) begin
		value_error("timer", 32'h0, irq_n[IRQ_TIMER]);
	end
	// Write 1 to EXP, IE kept
	bus_write(TMR_BASE + TMR_CTRL, 4'hf, (32'd1 << TMR_EXP) | (32'd1 << TMR_IE));
	if (irq_n[IRQ_TIMER] !== 1'b1) begin
		value_error("timer", 32'h1, irq_n[IRQ_TIMER]);
	end
	bus_read(TMR_BASE + TMR_CTRL, rdat);
	if (rdat !== (32'd1 << TMR_IE)) begin
		value_error("timer", 32'd1 << TMR_IE, rdat);
	end
	end_test("timer");
endtask

task automatic test_gpio();
	logic [GPIO_W-1:0] out_val;
	logic [GPIO_W-1:0] in_val;
	logic [31:0]       rdat;
	out_val = GPIO_W'(rand_bits(GPIO_W));
	bus_write(GPIO_BASE + GPIO_OUT, 4'hf, 32'(out_val));
	if (gpio_out !== out_val) begin
		value_error("gpio", out_val, gpio_out);
	end
	// Bit 4 forced high for the interrupt check
	in_val = GPIO_W'(rand_bits(GPIO_W)) | GPIO_W'(8'h10);
	@(posedge clk);
	gpio_in <= in_val;
	repeat (2) @(posedge clk);
	bus_read(GPIO_BASE + GPIO_IN, rdat);
	if (rdat !== 32'(in_val)) begin
		value_error("gpio", 32'(in_val), rdat);
	end
	bus_write(GPIO_BASE + GPIO_MASK, 4'hf, 32'h10);
	if (irq_n[IRQ_GPIO] !== 1'b0) begin
		value_error("gpio", 32'h0, irq_n[IRQ_GPIO]);
	end
	bus_write(GPIO_BASE + GPIO_MASK, 4'hf, 32'h0);
	if (irq_n[IRQ_GPIO] !== 1'b1) begin
		value_error("gpio", 32'h1, irq_n[IRQ_GPIO]);
	end
	gpio_in <= '0;
	end_test("gpio");
endtask

// No slave at this page, decoder answers with zero
task automatic test_unmapped();
	logic [31:0] rdat;
	bus_read(NONE_BASE, rdat);
	if (rdat !== 32'h0) begin
		value_error("unmapped", 32'h0, rdat);
	end
	end_test("unmapped");
endtask

//--- tb/tb_soc_top.sv
//--------------------------------------------------------------------------
// Testbench top for the memory-mapped subsystem
// Clock, reset, DUT, halfword SRAM pin model, bus tasks, LFSR
// Watchdog and result summary
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_soc_top;
	import soc_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_TESTS  = 6;
	localparam int ACK_LIMIT  = 100;
	// Model covers 2 KB of the SRAM
	localparam int MODEL_AW   = 10;

	// Slave bases, built from region and page fields
	localparam logic [31:0] BRAM_BASE = {PAGE_BRAM, 17'h0};
	localparam logic [31:0] SRAM_BASE = {REGION_SRAM, 29'h0};
	localparam logic [31:0] TMR_BASE  = {PAGE_TIMER, 17'h0};
	localparam logic [31:0] GPIO_BASE = {PAGE_GPIO, 17'h0};
	localparam logic [31:0] NONE_BASE = {15'h7005, 17'h0};

	logic              clk;
	logic              arst_n;
	bus_req_t          bus_req;
	bus_rsp_t          bus_rsp;
	mem_pins_t         mem_pins;
	logic [15:0]       mem_dq;
	logic [GPIO_W-1:0] gpio_in;
	logic [GPIO_W-1:0] gpio_out;
	logic [1:0]        irq_n;

	logic [15:0] sram_model [2**MODEL_AW];
	logic [31:0] lfsr_q;
	int          test_errs;
	int          pass_cnt;
	int          fail_cnt;

	always #(CLK_PERIOD/2) clk = ~clk;

	soc_top soc_top_inst (
		.clk_i     (clk),
		.arst_n_i  (arst_n),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp),
		.mem_o     (mem_pins),
		.mem_dq_i  (mem_dq),
		.gpio_i    (gpio_in),
		.gpio_o    (gpio_out),
		.irq_n_o   (irq_n)
	);

	//----------------------------------------------------------------------
	// SRAM pin model
	//----------------------------------------------------------------------
	// Byte lanes written while we_n is low
	always @(posedge clk) begin
		if (!mem_pins.ce_n && !mem_pins.we_n) begin
			if (!mem_pins.be_n[0]) begin
				sram_model[mem_pins.adr[MODEL_AW-1:0]][7:0] = mem_pins.dq[7:0];
			end
			if (!mem_pins.be_n[1]) begin
				sram_model[mem_pins.adr[MODEL_AW-1:0]][15:8] = mem_pins.dq[15:8];
			end
		end
	end

	// Drives data only during a read
	assign mem_dq = (!mem_pins.ce_n && !mem_pins.oe_n) ?
		sram_model[mem_pins.adr[MODEL_AW-1:0]] : 16'h0000;

	//----------------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// Selected bytes from the new word, others kept
	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
		input logic [31:0] nw, input logic [3:0] sel);
		logic [31:0] m;
		m = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old & ~m) | (nw & m);
	endfunction

	// Request held until ack, response sampled mid-cycle
	task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] wdat, output logic [31:0] rdat);
		int waited;
		waited = 0;
		rdat   = '0;
		@(posedge clk);
		bus_req <= '{stb: 1'b1, we: we, sel: sel, adr: bus_addr_u'(adr), wdat: wdat};
		do begin
			@(negedge clk);
			waited++;
		end while (!bus_rsp.ack && waited < ACK_LIMIT);
		if (bus_rsp.ack) begin
			rdat = bus_rsp.rdat;
		end else begin
			$display("Bus access to %h got no ack within %0d cycles", adr, ACK_LIMIT);
			test_errs++;
		end
		// Strobe drops in the cycle after ack
		@(posedge clk);
		bus_req <= '0;
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] wdat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, sel, wdat, unused);
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
		bus_cycle(1'b0, adr, 4'hf, 32'h0, rdat);
	endtask

	task automatic value_error(input string test, input logic [31:0] exp,
		input logic [31:0] act);
		$display("ERR %s expected %h actual %h", test, exp, act);
		test_errs++;
	endtask

	task automatic end_test(input string test);
		if (test_errs == 0) begin
			pass_cnt++;
			$display("%s passed", test);
		end else begin
			fail_cnt++;
			$display("%s failed with %0d errors", test, test_errs);
		end
		test_errs = 0;
	endtask

	`include "tb_soc_tests.svh"

	//----------------------------------------------------------------------
	// Sequence and summary
	//----------------------------------------------------------------------
	initial begin
		clk       = 1'b0;
		arst_n    <= 1'b0;
		bus_req   <= '0;
		gpio_in   <= '0;
		lfsr_q    = 32'hc1b4ba9e;
		test_errs = 0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		// Fill depends on the whole model address
		for (int i = 0; i < 2**MODEL_AW; i++) begin
			sram_model[i] = {6'h2d, MODEL_AW'(i)};
		end
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		test_reset_state();
		test_bram();
		test_sram();
		test_timer();
		test_gpio();
		test_unmapped();
		$display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Run time bound of 2000 cycles per test
	initial begin
		#(NUM_TESTS * 2000 * CLK_PERIOD);
		$display("Watchdog expired before all tests finished");
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- sim.f
+incdir+tb
logic/soc_pkg.sv
logic/soc_bus_decoder.sv
logic/soc_bram.sv
logic/soc_sram16_ctrl.sv
logic/soc_timer.sv
logic/soc_gpio.sv
logic/soc_top.sv
tb/tb_soc_top.sv

//--- Bender.yml
package:
  name: soc_subsystem

sources:
  # Package first, then the slaves, then the top level
  - files:
      - logic/soc_pkg.sv
      - logic/soc_bus_decoder.sv
      - logic/soc_bram.sv
      - logic/soc_sram16_ctrl.sv
      - logic/soc_timer.sv
      - logic/soc_gpio.sv
      - logic/soc_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_soc_top.sv
